// File: boot.hex
// Boot ROM image, one 16-bit hex word per line
// Line n holds the word at byte offset 2n from the ROM base
3C01
0F00
8C22
0004
2442
0001
AC22
0004
1000
FFFB
0000
1234
BEEF
CAFE
5A5A
A5C3

// File: run_sim.sh
#!/bin/sh
# Build the marin testbench with Verilator, run it, and pass only on the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/100ps -f sim.f --top-module marin_tb -o marin_sim

output=$(./obj_dir/marin_sim)
echo "$output"

if echo "$output" | grep -qx "PASS: all tests"; then
  exit 0
fi
exit 1

// File: sim.f
+incdir+src
src/wb_pkg.sv
src/periph_pkg.sv
src/wb_intercon.sv
src/bootrom16.sv
src/ram16bit_wb.sv
src/nexys7seg_wb.sv
src/uart_wb.sv
src/marin.sv
verification/marin_tb.sv

// File: src/bootrom16.sv
// Boot ROM on Wishbone, 16-bit words preloaded from boot.hex, one-clock read
`timescale 1ns/100ps
`include "soc_macros.svh"

module bootrom16 (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic [`WB_AW-1:0] wb_adr_i,
  input  logic [`WB_SW-1:0] wb_sel_i,
  input  logic              wb_we_i,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  output logic [`WB_DW-1:0] wb_dat_o,
  output logic              wb_ack_o
);

  localparam int AW = $clog2(`MEM_WORDS);

  logic [`WB_DW-1:0] mem [0:`MEM_WORDS-1];
  wb_pkg::wb_addr_u  adr;
  logic              req;

  initial $readmemh("boot.hex", mem);

  assign adr = wb_adr_i;
  // New access only while ack is low
  assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) wb_ack_o <= 1'b0;
    else wb_ack_o <= req;
  end

  // Writes get acked but never touch the array
  always_ff @(posedge clk_i) begin
    if (req && !wb_we_i && |wb_sel_i) wb_dat_o <= mem[adr.fld.offset[AW:1]];
  end

endmodule

// File: src/marin.sv
// Top level, Wishbone interconnect with boot ROM, display, UART and RAM driven by an external master
`timescale 1ns/100ps
`include "soc_macros.svh"

module marin (
  input  logic                 clk_100mhz_i,
  input  logic                 rst_i,
  input  logic [`WB_AW-1:0]    wbm_adr_i,
  input  logic [`WB_DW-1:0]    wbm_dat_i,
  input  logic [`WB_SW-1:0]    wbm_sel_i,
  input  logic                 wbm_we_i,
  input  logic                 wbm_cyc_i,
  input  logic                 wbm_stb_i,
  output logic [`WB_DW-1:0]    wbm_dat_o,
  output logic                 wbm_ack_o,
  input  logic                 rx_i,
  output logic                 tx_o,
  output periph_pkg::seg_pat_t seg_o,
  output logic [3:0]           an_o
);

  // Boot ROM, no write data
  logic [`WB_AW-1:0] wb2br_adr;
  logic [`WB_SW-1:0] wb2br_sel;
  logic              wb2br_we, wb2br_cyc, wb2br_stb, br2wb_ack;
  logic [`WB_DW-1:0] br2wb_dat;
  // Display, write only and address-free
  logic [`WB_DW-1:0] wb2dp_dat;
  logic [`WB_SW-1:0] wb2dp_sel;
  logic              wb2dp_we, wb2dp_cyc, wb2dp_stb, dp2wb_ack;
  // UART
  logic [`WB_AW-1:0] wb2ua_adr;
  logic [`WB_DW-1:0] wb2ua_dat, ua2wb_dat;
  logic [`WB_SW-1:0] wb2ua_sel;
  logic              wb2ua_we, wb2ua_cyc, wb2ua_stb, ua2wb_ack;
  // RAM
  logic [`WB_AW-1:0] wb2rm_adr;
  logic [`WB_DW-1:0] wb2rm_dat, rm2wb_dat;
  logic [`WB_SW-1:0] wb2rm_sel;
  logic              wb2rm_we, wb2rm_cyc, wb2rm_stb, rm2wb_ack;

  wb_intercon #(
    .slave_0_addr(`ROM_BASE),  .slave_0_mask(`ROM_MASK),
    .slave_1_addr(`DISP_BASE), .slave_1_mask(`DISP_MASK),
    .slave_2_addr(`UART_BASE), .slave_2_mask(`UART_MASK),
    .slave_3_addr(`RAM_BASE),  .slave_3_mask(`RAM_MASK)
  ) bus_intercon (
    .wbm_adr_i(wbm_adr_i), .wbm_dat_i(wbm_dat_i), .wbm_sel_i(wbm_sel_i),
    .wbm_we_i(wbm_we_i), .wbm_cyc_i(wbm_cyc_i), .wbm_stb_i(wbm_stb_i),
    .wbm_dat_o(wbm_dat_o), .wbm_ack_o(wbm_ack_o),
    .wbs_0_adr_o(wb2br_adr), .wbs_0_dat_o(), .wbs_0_sel_o(wb2br_sel),
    .wbs_0_we_o(wb2br_we), .wbs_0_cyc_o(wb2br_cyc), .wbs_0_stb_o(wb2br_stb),
    .wbs_0_dat_i(br2wb_dat), .wbs_0_ack_i(br2wb_ack),
    .wbs_1_adr_o(), .wbs_1_dat_o(wb2dp_dat), .wbs_1_sel_o(wb2dp_sel),
    .wbs_1_we_o(wb2dp_we), .wbs_1_cyc_o(wb2dp_cyc), .wbs_1_stb_o(wb2dp_stb),
    .wbs_1_dat_i({`WB_DW{1'b0}}), .wbs_1_ack_i(dp2wb_ack),
    .wbs_2_adr_o(wb2ua_adr), .wbs_2_dat_o(wb2ua_dat), .wbs_2_sel_o(wb2ua_sel),
    .wbs_2_we_o(wb2ua_we), .wbs_2_cyc_o(wb2ua_cyc), .wbs_2_stb_o(wb2ua_stb),
    .wbs_2_dat_i(ua2wb_dat), .wbs_2_ack_i(ua2wb_ack),
    .wbs_3_adr_o(wb2rm_adr), .wbs_3_dat_o(wb2rm_dat), .wbs_3_sel_o(wb2rm_sel),
    .wbs_3_we_o(wb2rm_we), .wbs_3_cyc_o(wb2rm_cyc), .wbs_3_stb_o(wb2rm_stb),
    .wbs_3_dat_i(rm2wb_dat), .wbs_3_ack_i(rm2wb_ack)
  );

  bootrom16 rom (
    .clk_i(clk_100mhz_i), .rst_i(rst_i), .wb_adr_i(wb2br_adr), .wb_sel_i(wb2br_sel),
    .wb_we_i(wb2br_we), .wb_cyc_i(wb2br_cyc), .wb_stb_i(wb2br_stb),
    .wb_dat_o(br2wb_dat), .wb_ack_o(br2wb_ack)
  );

  ram16bit_wb ram (
    .clk_i(clk_100mhz_i), .rst_i(rst_i), .wb_adr_i(wb2rm_adr), .wb_dat_i(wb2rm_dat),
    .wb_sel_i(wb2rm_sel), .wb_we_i(wb2rm_we), .wb_cyc_i(wb2rm_cyc),
    .wb_stb_i(wb2rm_stb), .wb_dat_o(rm2wb_dat), .wb_ack_o(rm2wb_ack)
  );

  nexys7seg_wb disp (
    .clk_i(clk_100mhz_i), .rst_i(rst_i), .wb_dat_i(wb2dp_dat), .wb_sel_i(wb2dp_sel),
    .wb_we_i(wb2dp_we), .wb_cyc_i(wb2dp_cyc), .wb_stb_i(wb2dp_stb),
    .wb_ack_o(dp2wb_ack), .seg_o(seg_o), .an_o(an_o)
  );

  uart_wb uart (
    .clk_i(clk_100mhz_i), .rst_i(rst_i), .wb_adr_i(wb2ua_adr), .wb_dat_i(wb2ua_dat),
    .wb_sel_i(wb2ua_sel), .wb_we_i(wb2ua_we), .wb_cyc_i(wb2ua_cyc),
    .wb_stb_i(wb2ua_stb), .wb_dat_o(ua2wb_dat), .wb_ack_o(ua2wb_ack),
    .rx_i(rx_i), .tx_o(tx_o)
  );

endmodule

// File: src/nexys7seg_wb.sv
// Four-digit seven-segment controller, one Wishbone register shown as hex with anode scan
`timescale 1ns/100ps
`include "soc_macros.svh"

module nexys7seg_wb (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic [`WB_DW-1:0]    wb_dat_i,
  input  logic [`WB_SW-1:0]    wb_sel_i,
  input  logic                 wb_we_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  output logic                 wb_ack_o,
  output periph_pkg::seg_pat_t seg_o,
  output logic [3:0]           an_o
);

  localparam int SW = $clog2(`SEG_SCAN);

  logic [`WB_DW-1:0] disp_q;
  logic [SW-1:0]     scan_cnt;
  logic [1:0]        digit_q;
  logic [3:0]        nib;
  logic              req;

  assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

  // Bus side, register written by byte lanes
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wb_ack_o <= 1'b0;
      disp_q   <= '0;
    end else begin
      wb_ack_o <= req;
      if (req && wb_we_i) begin
        for (int i = 0; i < `WB_SW; i++) begin
          if (wb_sel_i[i]) disp_q[8*i +: 8] <= wb_dat_i[8*i +: 8];
        end
      end
    end
  end

  // Scan, anodes dark until the first tick then digit 0 onward
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      scan_cnt <= '0;
      digit_q  <= '0;
      an_o     <= 4'b1111;
    end else if (scan_cnt == SW'(`SEG_SCAN - 1)) begin
      scan_cnt <= '0;
      if (an_o == 4'b1111) begin
        an_o <= 4'b1110;
      end else begin
        // Rotate the low anode, digit follows
        an_o    <= {an_o[2:0], an_o[3]};
        digit_q <= digit_q + 2'd1;
      end
    end else begin
      scan_cnt <= scan_cnt + SW'(1);
    end
  end

  assign nib = disp_q[{digit_q, 2'b00} +: 4];

  // Hex to segments, decimal point kept dark
  always_comb begin
    case (nib)
      4'h0: seg_o = 8'hC0;
      4'h1: seg_o = 8'hF9;
      4'h2: seg_o = 8'hA4;
      4'h3: seg_o = 8'hB0;
      4'h4: seg_o = 8'h99;
      4'h5: seg_o = 8'h92;
      4'h6: seg_o = 8'h82;
      4'h7: seg_o = 8'hF8;
      4'h8: seg_o = 8'h80;
      4'h9: seg_o = 8'h90;
      4'hA: seg_o = 8'h88;
      4'hB: seg_o = 8'h83;
      4'hC: seg_o = 8'hC6;
      4'hD: seg_o = 8'hA1;
      4'hE: seg_o = 8'h86;
      default: seg_o = 8'h8E;
    endcase
  end

endmodule

// File: src/periph_pkg.sv
// Peripheral-side types for the UART registers and the seven-segment display
package periph_pkg;

  // UART register select, taken from address bit 1
  typedef enum logic {
    UART_DATA = 1'b0,
    UART_STAT = 1'b1
  } uart_reg_e;

  // Bit positions inside the UART status word
  typedef enum int unsigned {
    STAT_RX_VALID = 0,
    STAT_TX_BUSY  = 1
  } uart_stat_bits;

  // Active-low segments, bit 7 is the decimal point
  // Bits 6..0 drive g..a
  typedef logic [7:0] seg_pat_t;

endpackage

// File: src/ram16bit_wb.sv
// Wishbone RAM of 16-bit words with byte-lane writes and a registered read
`timescale 1ns/100ps
`include "soc_macros.svh"

module ram16bit_wb (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic [`WB_AW-1:0] wb_adr_i,
  input  logic [`WB_DW-1:0] wb_dat_i,
  input  logic [`WB_SW-1:0] wb_sel_i,
  input  logic              wb_we_i,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  output logic [`WB_DW-1:0] wb_dat_o,
  output logic              wb_ack_o
);

  localparam int AW = $clog2(`MEM_WORDS);

  logic [`WB_DW-1:0] mem [0:`MEM_WORDS-1];
  wb_pkg::wb_addr_u  adr;
  logic [AW-1:0]     idx;
  logic              req;

  assign adr = wb_adr_i;
  // Word index from the byte offset field
  assign idx = adr.fld.offset[AW:1];
  assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) wb_ack_o <= 1'b0;
    else wb_ack_o <= req;
  end

  // Byte lanes written only where sel is set
  always_ff @(posedge clk_i) begin
    if (req && wb_we_i) begin
      for (int i = 0; i < `WB_SW; i++) begin
        if (wb_sel_i[i]) mem[idx][8*i +: 8] <= wb_dat_i[8*i +: 8];
      end
    end
  end

  // Read returns the old word, even on a write
  always_ff @(posedge clk_i) begin
    if (req) wb_dat_o <= mem[idx];
  end

endmodule

// File: src/soc_macros.svh
// Shared bus widths, slave address map and timing divisors, included by RTL and testbench
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Wishbone bus widths
`define WB_DW 16
`define WB_AW 32
`define WB_SW 2

// Slave address decode, base and mask
`define ROM_BASE  32'h0000_1000
`define ROM_MASK  32'hFFFF_F000
`define DISP_BASE 32'hF000_0000
`define DISP_MASK 32'hFFFF_FFFC
`define UART_BASE 32'hF000_0004
`define UART_MASK 32'hFFFF_FFFC
`define RAM_BASE  32'h1000_0000
`define RAM_MASK  32'hFFFF_F000

// Depth of ROM and RAM in 16-bit words
`define MEM_WORDS 2048

// Clocks per UART bit and per displayed digit
`define UART_DIV 8
`define SEG_SCAN 4

`endif

// File: src/uart_wb.sv
// 8N1 UART on Wishbone, data and status registers, write ack held while the transmitter is busy
`timescale 1ns/100ps
`include "soc_macros.svh"

module uart_wb (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic [`WB_AW-1:0] wb_adr_i,
  input  logic [`WB_DW-1:0] wb_dat_i,
  input  logic [`WB_SW-1:0] wb_sel_i,
  input  logic              wb_we_i,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  output logic [`WB_DW-1:0] wb_dat_o,
  output logic              wb_ack_o,
  input  logic              rx_i,
  output logic              tx_o
);

  localparam int DW = $clog2(`UART_DIV);

  periph_pkg::uart_reg_e reg_sel;
  logic              req, tx_wr, tx_go, rd_data;
  logic [`WB_DW-1:0] stat_word;
  // Transmitter
  logic              tx_busy;
  logic [9:0]        tx_shift;
  logic [3:0]        tx_bits;
  logic [DW-1:0]     tx_div;
  // Receiver
  logic              rx_meta, rx_s, rx_busy, rx_valid;
  logic [3:0]        rx_bits;
  logic [DW-1:0]     rx_div;
  logic [7:0]        rx_shift, rx_data;

  assign reg_sel = periph_pkg::uart_reg_e'(wb_adr_i[1]);
  assign req     = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign tx_wr   = req && wb_we_i && reg_sel == periph_pkg::UART_DATA && wb_sel_i[0];
  // Data write waits here until the frame ends
  assign tx_go   = tx_wr && !tx_busy;
  assign rd_data = req && !wb_we_i && reg_sel == periph_pkg::UART_DATA;

  always_comb begin
    stat_word = '0;
    stat_word[periph_pkg::STAT_RX_VALID] = rx_valid;
    stat_word[periph_pkg::STAT_TX_BUSY]  = tx_busy;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) wb_ack_o <= 1'b0;
    else wb_ack_o <= req && (!tx_wr || !tx_busy);
  end

  always_ff @(posedge clk_i) begin
    if (req && !wb_we_i) begin
      wb_dat_o <= (reg_sel == periph_pkg::UART_DATA) ? {8'h00, rx_data} : stat_word;
    end
  end

  // Frame is stop, data, start, shifted out LSB first one edge after the ack
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tx_busy <= 1'b0;
      tx_o    <= 1'b1;
      tx_bits <= '0;
      tx_div  <= '0;
    end else if (tx_go) begin
      tx_busy  <= 1'b1;
      tx_shift <= {1'b1, wb_dat_i[7:0], 1'b0};
      tx_bits  <= 4'd10;
      tx_div   <= '0;
    end else if (tx_busy) begin
      if (tx_div != '0) begin
        tx_div <= tx_div - DW'(1);
      end else if (tx_bits == '0) begin
        // Stop bit has run its full time
        tx_busy <= 1'b0;
      end else begin
        tx_o     <= tx_shift[0];
        tx_shift <= {1'b1, tx_shift[9:1]};
        tx_bits  <= tx_bits - 4'd1;
        tx_div   <= DW'(`UART_DIV - 1);
      end
    end
  end

  // Two-flop sync, then sample at mid-bit
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rx_meta  <= 1'b1;
      rx_s     <= 1'b1;
      rx_busy  <= 1'b0;
      rx_valid <= 1'b0;
      rx_bits  <= '0;
      rx_div   <= '0;
    end else begin
      rx_meta <= rx_i;
      rx_s    <= rx_meta;
      if (rd_data) rx_valid <= 1'b0;
      if (!rx_busy) begin
        if (!rx_s) begin
          rx_busy <= 1'b1;
          rx_bits <= '0;
          rx_div  <= DW'(`UART_DIV / 2 - 1);
        end
      end else if (rx_div != '0) begin
        rx_div <= rx_div - DW'(1);
      end else begin
        rx_div <= DW'(`UART_DIV - 1);
        if (rx_bits == '0) begin
          // Glitch, line back high at mid start bit
          if (rx_s) rx_busy <= 1'b0;
          else rx_bits <= 4'd1;
        end else if (rx_bits <= 4'd8) begin
          rx_shift <= {rx_s, rx_shift[7:1]};
          rx_bits  <= rx_bits + 4'd1;
        end else begin
          // Stop bit sampled, new byte wins over a read clear
          rx_busy  <= 1'b0;
          rx_data  <= rx_shift;
          rx_valid <= 1'b1;
        end
      end
    end
  end

endmodule

// File: src/wb_intercon.sv
// Single-master Wishbone interconnect, decodes four base/mask slaves and routes strobes and acks
`timescale 1ns/100ps
`include "soc_macros.svh"

module wb_intercon #(
  parameter logic [`WB_AW-1:0] slave_0_addr = `ROM_BASE,
  parameter logic [`WB_AW-1:0] slave_0_mask = `ROM_MASK,
  parameter logic [`WB_AW-1:0] slave_1_addr = `DISP_BASE,
  parameter logic [`WB_AW-1:0] slave_1_mask = `DISP_MASK,
  parameter logic [`WB_AW-1:0] slave_2_addr = `UART_BASE,
  parameter logic [`WB_AW-1:0] slave_2_mask = `UART_MASK,
  parameter logic [`WB_AW-1:0] slave_3_addr = `RAM_BASE,
  parameter logic [`WB_AW-1:0] slave_3_mask = `RAM_MASK
) (
  // Master side
  input  logic [`WB_AW-1:0] wbm_adr_i,
  input  logic [`WB_DW-1:0] wbm_dat_i,
  input  logic [`WB_SW-1:0] wbm_sel_i,
  input  logic              wbm_we_i,
  input  logic              wbm_cyc_i,
  input  logic              wbm_stb_i,
  output logic [`WB_DW-1:0] wbm_dat_o,
  output logic              wbm_ack_o,
  // Slave 0, boot ROM
  output logic [`WB_AW-1:0] wbs_0_adr_o,
  output logic [`WB_DW-1:0] wbs_0_dat_o,
  output logic [`WB_SW-1:0] wbs_0_sel_o,
  output logic              wbs_0_we_o,
  output logic              wbs_0_cyc_o,
  output logic              wbs_0_stb_o,
  input  logic [`WB_DW-1:0] wbs_0_dat_i,
  input  logic              wbs_0_ack_i,
  // Slave 1, display
  output logic [`WB_AW-1:0] wbs_1_adr_o,
  output logic [`WB_DW-1:0] wbs_1_dat_o,
  output logic [`WB_SW-1:0] wbs_1_sel_o,
  output logic              wbs_1_we_o,
  output logic              wbs_1_cyc_o,
  output logic              wbs_1_stb_o,
  input  logic [`WB_DW-1:0] wbs_1_dat_i,
  input  logic              wbs_1_ack_i,
  // Slave 2, UART
  output logic [`WB_AW-1:0] wbs_2_adr_o,
  output logic [`WB_DW-1:0] wbs_2_dat_o,
  output logic [`WB_SW-1:0] wbs_2_sel_o,
  output logic              wbs_2_we_o,
  output logic              wbs_2_cyc_o,
  output logic              wbs_2_stb_o,
  input  logic [`WB_DW-1:0] wbs_2_dat_i,
  input  logic              wbs_2_ack_i,
  // Slave 3, RAM
  output logic [`WB_AW-1:0] wbs_3_adr_o,
  output logic [`WB_DW-1:0] wbs_3_dat_o,
  output logic [`WB_SW-1:0] wbs_3_sel_o,
  output logic              wbs_3_we_o,
  output logic              wbs_3_cyc_o,
  output logic              wbs_3_stb_o,
  input  logic [`WB_DW-1:0] wbs_3_dat_i,
  input  logic              wbs_3_ack_i
);

  wb_pkg::wb_addr_u  adr;
  wb_pkg::wb_slave_e slv;

  assign adr = wbm_adr_i;

  // Priority decode on the raw address view
  always_comb begin
    if ((adr.raw & slave_0_mask) == slave_0_addr) slv = wb_pkg::SLV_ROM;
    else if ((adr.raw & slave_1_mask) == slave_1_addr) slv = wb_pkg::SLV_DISP;
    else if ((adr.raw & slave_2_mask) == slave_2_addr) slv = wb_pkg::SLV_UART;
    else if ((adr.raw & slave_3_mask) == slave_3_addr) slv = wb_pkg::SLV_RAM;
    else slv = wb_pkg::SLV_NONE;
  end

  // Address, data, select and write enable go to every slave
  assign {wbs_0_adr_o, wbs_1_adr_o, wbs_2_adr_o, wbs_3_adr_o} = {4{wbm_adr_i}};
  assign {wbs_0_dat_o, wbs_1_dat_o, wbs_2_dat_o, wbs_3_dat_o} = {4{wbm_dat_i}};
  assign {wbs_0_sel_o, wbs_1_sel_o, wbs_2_sel_o, wbs_3_sel_o} = {4{wbm_sel_i}};
  assign {wbs_0_we_o, wbs_1_we_o, wbs_2_we_o, wbs_3_we_o} = {4{wbm_we_i}};

  // Cycle and strobe only on the selected slave
  assign wbs_0_cyc_o = wbm_cyc_i && (slv == wb_pkg::SLV_ROM);
  assign wbs_1_cyc_o = wbm_cyc_i && (slv == wb_pkg::SLV_DISP);
  assign wbs_2_cyc_o = wbm_cyc_i && (slv == wb_pkg::SLV_UART);
  assign wbs_3_cyc_o = wbm_cyc_i && (slv == wb_pkg::SLV_RAM);
  assign wbs_0_stb_o = wbm_stb_i && (slv == wb_pkg::SLV_ROM);
  assign wbs_1_stb_o = wbm_stb_i && (slv == wb_pkg::SLV_DISP);
  assign wbs_2_stb_o = wbm_stb_i && (slv == wb_pkg::SLV_UART);
  assign wbs_3_stb_o = wbm_stb_i && (slv == wb_pkg::SLV_RAM);

  // Return path, a miss acks at once with zero data
  always_comb begin
    case (slv)
      wb_pkg::SLV_ROM:  {wbm_dat_o, wbm_ack_o} = {wbs_0_dat_i, wbs_0_ack_i};
      wb_pkg::SLV_DISP: {wbm_dat_o, wbm_ack_o} = {wbs_1_dat_i, wbs_1_ack_i};
      wb_pkg::SLV_UART: {wbm_dat_o, wbm_ack_o} = {wbs_2_dat_i, wbs_2_ack_i};
      wb_pkg::SLV_RAM:  {wbm_dat_o, wbm_ack_o} = {wbs_3_dat_i, wbs_3_ack_i};
      default:          {wbm_dat_o, wbm_ack_o} = {{`WB_DW{1'b0}}, wbm_cyc_i & wbm_stb_i};
    endcase
  end

endmodule

// File: src/wb_pkg.sv
// Bus-side types shared by the interconnect, the memories and the testbench
`include "soc_macros.svh"

package wb_pkg;

  // One address word, seen whole for decode or split for memory indexing
  typedef union packed {
    logic [`WB_AW-1:0] raw;
    struct packed {
      logic [19:0] page;
      logic [11:0] offset;
    } fld;
  } wb_addr_u;

  // Slave picked by the decoder, lowest index first
  typedef enum logic [2:0] {
    SLV_ROM,
    SLV_DISP,
    SLV_UART,
    SLV_RAM,
    SLV_NONE
  } wb_slave_e;

endpackage

// File: verification/marin_tb.sv
// Testbench for marin, plays the Wishbone master and checks each slave against reference models
`timescale 1ns/100ps
`include "soc_macros.svh"

module marin_tb;

  localparam int CLK_PERIOD = 20;
  localparam int FRAME_CLKS = 10 * `UART_DIV;
  // A UART write may sit behind a whole frame
  localparam int ACK_LIMIT = 2 * FRAME_CLKS;
  localparam int RAM_TESTS = 64;
  localparam int TEST_COUNT = 6;
  // Up to four frames per test, plus a few clocks per memory access
  localparam int WATCHDOG_NS =
    CLK_PERIOD * (TEST_COUNT * 4 * FRAME_CLKS + 8 * (3 * RAM_TESTS) + 400);

  logic                 clk;
  logic                 rst_i;
  logic [`WB_AW-1:0]    wbm_adr_i;
  logic [`WB_DW-1:0]    wbm_dat_i;
  logic [`WB_SW-1:0]    wbm_sel_i;
  logic                 wbm_we_i;
  logic                 wbm_cyc_i;
  logic                 wbm_stb_i;
  logic [`WB_DW-1:0]    wbm_dat_o;
  logic                 wbm_ack_o;
  logic                 rx_i;
  logic                 tx_o;
  periph_pkg::seg_pat_t seg_o;
  logic [3:0]           an_o;

  // Reference images
  logic [15:0] rom_img [0:15];
  logic [15:0] model_ram [0:`MEM_WORDS-1];
  logic [10:0] ram_idx [0:RAM_TESTS-1];
  logic [31:0] lcg_state;
  int          errors;
  int          checks;
  // Pending comparisons, drained on each rising edge
  string       name_q[$];
  logic [15:0] exp_q[$];
  logic [15:0] act_q[$];
  string       chk_name;
  logic [15:0] chk_exp;
  logic [15:0] chk_act;

  marin UUT (
    .clk_100mhz_i(clk), .rst_i(rst_i), .wbm_adr_i(wbm_adr_i), .wbm_dat_i(wbm_dat_i),
    .wbm_sel_i(wbm_sel_i), .wbm_we_i(wbm_we_i), .wbm_cyc_i(wbm_cyc_i),
    .wbm_stb_i(wbm_stb_i), .wbm_dat_o(wbm_dat_o), .wbm_ack_o(wbm_ack_o),
    .rx_i(rx_i), .tx_o(tx_o), .seg_o(seg_o), .an_o(an_o)
  );

  // Serial loopback, line idle during reset
  assign rx_i = rst_i ? 1'b1 : tx_o;

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_step();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Segments lit per digit as gfedcba, then inverted
  function automatic periph_pkg::seg_pat_t hex_to_seg(input logic [3:0] nib);
    logic [6:0] lit;
    case (nib)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h6F;
      4'hA: lit = 7'h77;
      4'hB: lit = 7'h7C;
      4'hC: lit = 7'h39;
      4'hD: lit = 7'h5E;
      4'hE: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    return {1'b1, ~lit};
  endfunction

  // Lowest matching base/mask wins, a miss reads zero
  function automatic wb_pkg::wb_slave_e expected_read(input logic [31:0] adr,
                                                      output logic [15:0] dat);
    wb_pkg::wb_addr_u a;
    logic [10:0]      w;
    a = adr;
    w = a.fld.offset[11:1];
    dat = 16'h0000;
    if ((a.raw & `ROM_MASK) == `ROM_BASE) begin
      if (w < 11'd16) dat = rom_img[w[3:0]];
      return wb_pkg::SLV_ROM;
    end
    if ((a.raw & `DISP_MASK) == `DISP_BASE) return wb_pkg::SLV_DISP;
    if ((a.raw & `UART_MASK) == `UART_BASE) return wb_pkg::SLV_UART;
    if ((a.raw & `RAM_MASK) == `RAM_BASE) begin
      dat = model_ram[w];
      return wb_pkg::SLV_RAM;
    end
    return wb_pkg::SLV_NONE;
  endfunction

  task automatic post_check(input string name, input logic [15:0] exp, input logic [15:0] act);
    name_q.push_back(name);
    exp_q.push_back(exp);
    act_q.push_back(act);
  endtask

  // Entered and left 2 ns after a rising edge, lat counts falling edges up to ack
  task automatic bus_cycle(input logic [31:0] adr, input logic [15:0] wdat,
                           input logic [1:0] sel, input logic we,
                           output logic [15:0] rdat, output int lat);
    lat = 0;
    wbm_adr_i = adr;
    wbm_dat_i = wdat;
    wbm_sel_i = sel;
    wbm_we_i  = we;
    wbm_cyc_i = 1'b1;
    wbm_stb_i = 1'b1;
    do begin
      @(negedge clk);
      lat++;
    end while (!wbm_ack_o && lat < ACK_LIMIT);
    rdat = wbm_dat_o;
    if (!wbm_ack_o) begin
      errors++;
      $display("No ack from address %h within %0d cycles", adr, lat);
    end
    @(posedge clk);
    #2;
    wbm_cyc_i = 1'b0;
    wbm_stb_i = 1'b0;
    wbm_we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [15:0] dat,
                          input logic [1:0] sel, output int lat);
    logic [15:0] unused;
    bus_cycle(adr, dat, sel, 1'b1, unused, lat);
  endtask

  task automatic wb_read(input logic [31:0] adr, output logic [15:0] dat, output int lat);
    bus_cycle(adr, 16'h0000, 2'b11, 1'b0, dat, lat);
  endtask

  task automatic read_and_compare(input logic [31:0] adr);
    logic [15:0]       exp_dat;
    logic [15:0]       act_dat;
    int                lat;
    wb_pkg::wb_slave_e slv;
    slv = expected_read(adr, exp_dat);
    wb_read(adr, act_dat, lat);
    post_check("wbm_dat_o", exp_dat, act_dat);
    // Miss acks in the same cycle, mapped slaves one clock later
    post_check("ack latency", (slv == wb_pkg::SLV_NONE) ? 16'd1 : 16'd2, lat[15:0]);
  endtask

  // Two full scan rounds
  task automatic check_display(input logic [15:0] val);
    logic [3:0] seen;
    seen = 4'h0;
    repeat (2 * 4 * `SEG_SCAN) begin
      @(negedge clk);
      if ($countones(an_o) != 3) begin
        errors++;
        $display("Anode pattern %b at %0t ns does not light exactly one digit", an_o, $time);
      end
      for (int k = 0; k < 4; k++) begin
        if (!an_o[k]) begin
          seen[k] = 1'b1;
          post_check("seg_o", {8'h00, hex_to_seg(val[4*k +: 4])}, {8'h00, seg_o});
        end
      end
    end
    if (seen != 4'hF) begin
      errors++;
      $display("Display scan skipped digits, seen mask %b", seen);
    end
    @(posedge clk);
    #2;
  endtask

  task automatic wait_rx_valid();
    logic [15:0] stat;
    int          lat;
    int          polls;
    polls = 0;
    do begin
      wb_read(`UART_BASE + 32'd2, stat, lat);
      polls++;
    end while (!stat[periph_pkg::STAT_RX_VALID] && polls < 2 * FRAME_CLKS);
    if (!stat[periph_pkg::STAT_RX_VALID]) begin
      errors++;
      $display("UART rx_valid never set after %0d status reads", polls);
    end
  endtask

  // Compare process
  initial begin
    forever begin
      @(posedge clk);
      while (exp_q.size() > 0) begin
        chk_name = name_q.pop_front();
        chk_exp  = exp_q.pop_front();
        chk_act  = act_q.pop_front();
        checks++;
        if (chk_act !== chk_exp) begin
          errors++;
          $display("ERROR at %0t ns: %s expected %h, actual %h", $time, chk_name, chk_exp,
                   chk_act);
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [15:0] d;
    logic [15:0] rd;
    logic [15:0] val;
    logic [1:0]  sel;
    logic [7:0]  b1;
    logic [7:0]  b2;
    logic [10:0] w;
    int          lat;
    int          lat2;
    lcg_state = 32'h3f53;
    errors    = 0;
    checks    = 0;
    rst_i     = 1'b1;
    wbm_adr_i = '0;
    wbm_dat_i = '0;
    wbm_sel_i = '0;
    wbm_we_i  = 1'b0;
    wbm_cyc_i = 1'b0;
    wbm_stb_i = 1'b0;
    $readmemh("boot.hex", rom_img);
    repeat (3) @(posedge clk);
    #2 rst_i = 1'b0;
    // Idle outputs right after reset
    @(negedge clk);
    post_check("tx_o", 16'd1, {15'd0, tx_o});
    post_check("an_o", 16'h000F, {12'd0, an_o});
    post_check("wbm_ack_o", 16'd0, {15'd0, wbm_ack_o});
    @(posedge clk);
    #2;

    // ROM image, a write that must not stick, odd byte alias of word 0
    for (int i = 0; i < 16; i++) begin
      read_and_compare(`ROM_BASE + 32'(2 * i));
    end
    wb_write(`ROM_BASE + 32'd6, ~rom_img[3], 2'b11, lat);
    read_and_compare(`ROM_BASE + 32'd6);
    read_and_compare(`ROM_BASE + 32'd1);

    // RAM prefill of random words
    for (int i = 0; i < RAM_TESTS; i++) begin
      r = lcg_step();
      ram_idx[i] = r[31:21];
      r = lcg_step();
      d = r[31:16];
      wb_write(`RAM_BASE + {20'd0, ram_idx[i], 1'b0}, d, 2'b11, lat);
      model_ram[ram_idx[i]] = d;
    end
    // Random byte lanes over the same words
    for (int i = 0; i < RAM_TESTS; i++) begin
      r = lcg_step();
      w = ram_idx[r[31:26]];
      sel = r[25:24];
      d = r[23:8];
      wb_write(`RAM_BASE + {20'd0, w, 1'b0}, d, sel, lat);
      if (sel[0]) model_ram[w][7:0] = d[7:0];
      if (sel[1]) model_ram[w][15:8] = d[15:8];
    end
    for (int i = 0; i < RAM_TESTS; i++) begin
      read_and_compare(`RAM_BASE + {20'd0, ram_idx[i], 1'b0});
    end
    wb_write(`RAM_BASE + 32'h0000_0FFF, 16'hA55A, 2'b11, lat);
    model_ram[11'h7FF] = 16'hA55A;
    read_and_compare(`RAM_BASE + 32'h0000_0FFE);

    // Misses, then one step outside each mask
    read_and_compare(32'h0000_0000);
    read_and_compare(32'h8000_0000);
    read_and_compare(32'h0000_0FFE);
    read_and_compare(32'h0000_2000);
    read_and_compare(32'hEFFF_FFFE);
    read_and_compare(32'hF000_0008);
    read_and_compare(32'h0FFF_FFFE);
    read_and_compare(32'h1000_1000);

    // Display through an aliased address, then low byte only
    r = lcg_step();
    val = r[31:16];
    wb_write(`DISP_BASE + 32'd2, val, 2'b11, lat);
    check_display(val);
    r = lcg_step();
    wb_write(`DISP_BASE, r[31:16], 2'b01, lat);
    val[7:0] = r[23:16];
    check_display(val);

    // UART loopback, status read once through the alias
    r = lcg_step();
    b1 = r[31:24];
    wb_write(`UART_BASE, {8'h00, b1}, 2'b01, lat);
    post_check("uart write latency", 16'd2, lat[15:0]);
    wait_rx_valid();
    wb_read(`UART_BASE + 32'd3, rd, lat);
    post_check("rx_valid", 16'd1, {15'd0, rd[periph_pkg::STAT_RX_VALID]});
    wb_read(`UART_BASE, rd, lat);
    post_check("uart rx data", {8'h00, b1}, rd);
    wb_read(`UART_BASE + 32'd2, rd, lat);
    post_check("rx_valid", 16'd0, {15'd0, rd[periph_pkg::STAT_RX_VALID]});

    // Back-to-back writes, second one held until the first frame ends
    r = lcg_step();
    b1 = r[31:24];
    b2 = r[23:16];
    wb_write(`UART_BASE, {8'h00, b1}, 2'b01, lat);
    wb_write(`UART_BASE, {8'h00, b2}, 2'b01, lat2);
    if (lat2 < FRAME_CLKS) begin
      errors++;
      $display("Second UART write acked after %0d cycles, before the %0d-cycle frame ended",
               lat2, FRAME_CLKS);
    end
    wait_rx_valid();
    wb_read(`UART_BASE, rd, lat);
    post_check("uart rx data", {8'h00, b1}, rd);
    wait_rx_valid();
    wb_read(`UART_BASE, rd, lat);
    post_check("uart rx data", {8'h00, b2}, rd);

    repeat (2) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) $display("PASS: all tests");
    else $display("FAIL: see errors above");
    $finish;
  end

endmodule
